/* isa_pkg.sv */
package isa_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;
    localparam int op_width       = 6;
    localparam int funct_width    = 6;
    localparam int shamt_width    = 5;
    localparam int imm_width      = 16;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // immediate overlays rd, shamt and funct
    typedef struct packed {
        logic [op_width-1:0]    op;
        reg_addr_t              rs;
        reg_addr_t              rt;
        reg_addr_t              rd;
        logic [shamt_width-1:0] shamt;
        logic [funct_width-1:0] funct;
    } instr_t;

    localparam logic [op_width-1:0] op_rtype = 6'h00;
    localparam logic [op_width-1:0] op_addi  = 6'h08;
    localparam logic [op_width-1:0] op_addiu = 6'h09;
    localparam logic [op_width-1:0] op_slti  = 6'h0a;
    localparam logic [op_width-1:0] op_sltiu = 6'h0b;
    localparam logic [op_width-1:0] op_andi  = 6'h0c;
    localparam logic [op_width-1:0] op_ori   = 6'h0d;
    localparam logic [op_width-1:0] op_xori  = 6'h0e;
    localparam logic [op_width-1:0] op_lui   = 6'h0f;

    localparam logic [funct_width-1:0] fn_sll  = 6'h00;
    localparam logic [funct_width-1:0] fn_srl  = 6'h02;
    localparam logic [funct_width-1:0] fn_sra  = 6'h03;
    localparam logic [funct_width-1:0] fn_add  = 6'h20;
    localparam logic [funct_width-1:0] fn_addu = 6'h21;
    localparam logic [funct_width-1:0] fn_sub  = 6'h22;
    localparam logic [funct_width-1:0] fn_subu = 6'h23;
    localparam logic [funct_width-1:0] fn_and  = 6'h24;
    localparam logic [funct_width-1:0] fn_or   = 6'h25;
    localparam logic [funct_width-1:0] fn_xor  = 6'h26;
    localparam logic [funct_width-1:0] fn_nor  = 6'h27;
    localparam logic [funct_width-1:0] fn_slt  = 6'h2a;
    localparam logic [funct_width-1:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    // decode to execute
    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        alu_op_t                alu_op;
        reg_addr_t              src1;
        reg_addr_t              src2;
        reg_addr_t              dest;
        logic                   use_imm;
        logic [shamt_width-1:0] shamt;
        word_t                  imm;
    } ex_ctrl_t;

    // writeback port, also the register file write port
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

endpackage

/* instr_decode.sv */
module instr_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     instr_valid,
    input  instr_t   instr,
    output ex_ctrl_t ex_ctrl
);

    logic [imm_width-1:0] imm16;
    word_t                sign_imm;
    word_t                zero_imm;
    logic                 known;

    assign imm16    = instr[imm_width-1:0];
    assign sign_imm = {{(word_width - imm_width){imm16[imm_width-1]}}, imm16};
    assign zero_imm = {{(word_width - imm_width){1'b0}}, imm16};

    always_comb begin
        known           = 1'b1;
        ex_ctrl.src1    = instr.rs;
        ex_ctrl.src2    = instr.rt;
        ex_ctrl.shamt   = instr.shamt;
        ex_ctrl.alu_op  = alu_add;
        ex_ctrl.use_imm = 1'b1;
        ex_ctrl.imm     = sign_imm;
        ex_ctrl.dest    = instr.rt;

        case (instr.op)
            op_rtype: begin
                ex_ctrl.use_imm = 1'b0;
                ex_ctrl.imm     = '0;
                ex_ctrl.dest    = instr.rd;
                case (instr.funct)
                    fn_add, fn_addu: ex_ctrl.alu_op = alu_add;
                    fn_sub, fn_subu: ex_ctrl.alu_op = alu_sub;
                    fn_and:          ex_ctrl.alu_op = alu_and;
                    fn_or:           ex_ctrl.alu_op = alu_or;
                    fn_xor:          ex_ctrl.alu_op = alu_xor;
                    fn_nor:          ex_ctrl.alu_op = alu_nor;
                    fn_slt:          ex_ctrl.alu_op = alu_slt;
                    fn_sltu:         ex_ctrl.alu_op = alu_sltu;
                    fn_sll:          ex_ctrl.alu_op = alu_sll;
                    fn_srl:          ex_ctrl.alu_op = alu_srl;
                    fn_sra:          ex_ctrl.alu_op = alu_sra;
                    default:         known = 1'b0;
                endcase
            end
            op_addi, op_addiu: ex_ctrl.alu_op = alu_add;
            // sltiu compares unsigned against the sign-extended immediate
            op_slti:  ex_ctrl.alu_op = alu_slt;
            op_sltiu: ex_ctrl.alu_op = alu_sltu;
            op_andi: begin
                ex_ctrl.alu_op = alu_and;
                ex_ctrl.imm    = zero_imm;
            end
            op_ori: begin
                ex_ctrl.alu_op = alu_or;
                ex_ctrl.imm    = zero_imm;
            end
            op_xori: begin
                ex_ctrl.alu_op = alu_xor;
                ex_ctrl.imm    = zero_imm;
            end
            op_lui: begin
                ex_ctrl.alu_op = alu_lui;
                ex_ctrl.imm    = zero_imm;
            end
            default: known = 1'b0;
        endcase

        // unknown encodings never reach writeback
        ex_ctrl.reg_write = known;
        ex_ctrl.valid     = instr_valid & known;
    end

endmodule

/* register_file.sv */
module register_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    input  wb_t       wb,
    output word_t     rd_data1,
    output word_t     rd_data2
);

    // r0 is cleared by reset and never written
    word_t regs [reg_count];

    logic wr_en;

    assign wr_en = wb.valid && (wb.dest != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through covers a reader two instructions behind the writer
    assign rd_data1 = (wr_en && (wb.dest == rd_addr1)) ? wb.data : regs[rd_addr1];
    assign rd_data2 = (wr_en && (wb.dest == rd_addr2)) ? wb.data : regs[rd_addr2];

    // holds even while a writeback to r0 is on the port
    a_zero_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rd_addr1 != '0) || (rd_data1 == '0)) &&
        ((rd_addr2 != '0) || (rd_data2 == '0))
    );

endmodule

/* execute_stage.sv */
module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ex_ctrl_t ex_ctrl,
    input  word_t    rd_data1,
    input  word_t    rd_data2,
    output wb_t      wb
);

    ex_ctrl_t ex_q;
    word_t    op1_q;
    word_t    op2_q;
    logic     fwd1;
    logic     fwd2;
    word_t    src_a;
    word_t    rt_val;
    word_t    src_b;
    word_t    alu_result;

    // decode/execute register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        op1_q <= rd_data1;
        op2_q <= rd_data2;
    end

    // producer one instruction ahead sits in wb
    assign fwd1 = wb.valid && (wb.dest != '0) && (wb.dest == ex_q.src1);
    assign fwd2 = wb.valid && (wb.dest != '0) && (wb.dest == ex_q.src2);

    assign src_a  = fwd1 ? wb.data : op1_q;
    assign rt_val = fwd2 ? wb.data : op2_q;
    assign src_b  = ex_q.use_imm ? ex_q.imm : rt_val;

    always_comb begin
        case (ex_q.alu_op)
            alu_add:  alu_result = src_a + src_b;
            alu_sub:  alu_result = src_a - src_b;
            alu_and:  alu_result = src_a & src_b;
            alu_or:   alu_result = src_a | src_b;
            alu_xor:  alu_result = src_a ^ src_b;
            alu_nor:  alu_result = ~(src_a | src_b);
            alu_slt:  alu_result = {{(word_width - 1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_sltu: alu_result = {{(word_width - 1){1'b0}}, src_a < src_b};
            // shifts act on rt
            alu_sll:  alu_result = src_b << ex_q.shamt;
            alu_srl:  alu_result = src_b >> ex_q.shamt;
            alu_sra:  alu_result = word_t'($signed(src_b) >>> ex_q.shamt);
            alu_lui:  alu_result = {src_b[imm_width-1:0], {(word_width - imm_width){1'b0}}};
            default:  alu_result = '0;
        endcase
    end

    // writeback register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= ex_q.valid && ex_q.reg_write;
            wb.dest  <= ex_q.dest;
            wb.data  <= alu_result;
        end
    end

    // two edges from the decoded strobe to the writeback strobe
    a_wb_follows_ex: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.valid |-> $past(ex_ctrl.valid, 2)
    );

    a_wb_dest_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.valid |-> !$isunknown(wb.dest)
    );

endmodule

/* mips_core.sv */
module mips_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  instr_t instr,
    output wb_t    wb
);

    ex_ctrl_t ex_ctrl;
    word_t    rd_data1;
    word_t    rd_data2;

    // decode and register read see the same word
    instr_decode u_instr_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex_ctrl     (ex_ctrl)
    );

    register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (instr.rs),
        .rd_addr2 (instr.rt),
        .wb       (wb),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_ctrl  (ex_ctrl),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb       (wb)
    );

endmodule

/* wb_checker.sv */
module wb_checker
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  instr_t instr,
    input  wb_t    wb,
    output int     checks,
    output int     errors,
    output int     pending
);

    typedef struct packed {
        logic [31:0] due;
        reg_addr_t   dest;
        word_t       data;
    } expect_t;

    word_t       model_regs [reg_count];
    expect_t     exp_q [$];
    expect_t     head;
    logic [31:0] edge_count;

    function automatic logic is_kept(input instr_t ins);
        logic kept;
        kept = 1'b0;
        if (ins.op == op_rtype) begin
            case (ins.funct)
                fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor,
                fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra: kept = 1'b1;
                default: kept = 1'b0;
            endcase
        end else begin
            kept = (ins.op >= op_addi) && (ins.op <= op_lui);
        end
        return kept;
    endfunction

    // ISA semantics, a is rs and b is rt
    function automatic word_t model_result(input instr_t ins, input word_t a, input word_t b);
        word_t simm;
        word_t zimm;
        word_t res;
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        res  = '0;
        if (ins.op == op_rtype) begin
            case (ins.funct)
                fn_add, fn_addu: res = a + b;
                fn_sub, fn_subu: res = a - b;
                fn_and:          res = a & b;
                fn_or:           res = a | b;
                fn_xor:          res = a ^ b;
                fn_nor:          res = ~(a | b);
                fn_slt:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fn_sltu:         res = (a < b) ? 32'd1 : 32'd0;
                fn_sll:          res = b << ins.shamt;
                fn_srl:          res = b >> ins.shamt;
                fn_sra:          res = word_t'($signed(b) >>> ins.shamt);
                default:         res = '0;
            endcase
        end else begin
            case (ins.op)
                op_addi, op_addiu: res = a + simm;
                op_slti:           res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                op_sltiu:          res = (a < simm) ? 32'd1 : 32'd0;
                op_andi:           res = a & zimm;
                op_ori:            res = a | zimm;
                op_xori:           res = a ^ zimm;
                op_lui:            res = {ins[15:0], 16'h0000};
                default:           res = '0;
            endcase
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                model_regs[i] = '0;
            end
            exp_q.delete();
            edge_count = '0;
            checks     = 0;
            errors     = 0;
        end else begin
            if (wb.valid) begin
                if (exp_q.size() > 0 && exp_q[0].due == edge_count) begin
                    head = exp_q.pop_front();
                    checks++;
                    if (wb.dest !== head.dest) begin
                        $display("[ERROR] wb.dest expected 0x%02h actual 0x%02h",
                                 head.dest, wb.dest);
                        errors++;
                    end
                    if (wb.data !== head.data) begin
                        $display("[ERROR] wb.data expected 0x%08h actual 0x%08h",
                                 head.data, wb.data);
                        errors++;
                    end
                end else begin
                    $display("unexpected writeback strobe to r%0d at edge %0d",
                             wb.dest, edge_count);
                    errors++;
                end
            end
            if (exp_q.size() > 0 && exp_q[0].due <= edge_count) begin
                head = exp_q.pop_front();
                $display("missing writeback to r%0d due at edge %0d", head.dest, head.due);
                errors++;
            end
            // model updates in issue order
            if (instr_valid && is_kept(instr)) begin
                head.due  = edge_count + 2;
                head.dest = (instr.op == op_rtype) ? instr.rd : instr.rt;
                head.data = model_result(instr, model_regs[instr.rs], model_regs[instr.rt]);
                exp_q.push_back(head);
                if (head.dest != '0) begin
                    model_regs[head.dest] = head.data;
                end
            end
            edge_count++;
        end
        pending = exp_q.size();
    end

endmodule

/* tb_mips_core.sv */
module tb_mips_core
    import isa_pkg::*;
    import pipe_pkg::*;
();

    // 500 instructions and at most 300 idle cycles
    localparam int timeout_cycles = 2 * (500 + 300) + 50;

    localparam logic [5:0] kept_functs [0:12] = '{
        fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor,
        fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra
    };

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_t      instr;
    wb_t         wb;
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          checks;
    int          errors;
    int          pending;

    mips_core UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    wb_checker u_wb_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .checks      (checks),
        .errors      (errors),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic make_instr(input logic narrow, input logic allow_unknown,
                              output instr_t ins);
        logic [31:0] fields;
        logic [31:0] pick;
        logic [31:0] sel;
        take_bits(26, fields);
        ins = instr_t'({6'h00, fields[25:0]});
        take_bits(1, pick);
        if (pick[0]) begin
            take_bits(4, pick);
            sel       = pick % 32'd13;
            ins.op    = op_rtype;
            ins.funct = kept_functs[sel[3:0]];
            if (narrow) begin
                ins.rd[4:2] = '0;
            end
        end else begin
            // I-type opcodes 0x08 to 0x0f are all kept
            take_bits(3, pick);
            ins.op = op_addi | {3'b000, pick[2:0]};
        end
        if (narrow) begin
            ins.rs[4:2] = '0;
            ins.rt[4:2] = '0;
        end
        if (allow_unknown) begin
            take_bits(3, pick);
            if (pick[2:0] == 3'd0) begin
                // load opcodes, not decoded here
                ins.op = {3'b100, ins.rs[2:0]};
            end
        end
    endtask

    task automatic issue(input instr_t ins);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = ins;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (3) idle_cycle();
    endtask

    task automatic run_test(input string name, input int count, input logic narrow,
                            input logic sparse);
        instr_t      ins;
        logic [31:0] gap;
        int          errors_before;
        errors_before = errors;
        for (int n = 0; n < count; n++) begin
            make_instr(narrow, sparse, ins);
            issue(ins);
            if (sparse) begin
                take_bits(2, gap);
                repeat (gap) idle_cycle();
            end
        end
        drain();
        $display("%s: %0d instructions, %0d errors", name, count, errors - errors_before);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'd81921;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_test("random alu", 200, 1'b0, 1'b0);
        run_test("dependence chains", 200, 1'b1, 1'b0);
        run_test("sparse issue", 100, 1'b0, 1'b1);
        $display("%0d writebacks checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
isa_pkg.sv
pipe_pkg.sv
instr_decode.sv
register_file.sv
execute_stage.sv
mips_core.sv
wb_checker.sv
tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module tb_mips_core -o tb_mips_core &&
out=$(./obj_dir/tb_mips_core 2>&1)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
